//--- verilog/f2fix_pkg.sv
`default_nettype none

package f2fix_pkg;

    localparam int INT_WID  = 16;
    localparam int FRA_WID  = 16;
    localparam int EXP_WID  = 8;
    localparam int MANT_WID = 23;
    localparam int EXP_BIAS = 127;

    localparam int EXP_UPPER_BOUND = INT_WID - 2;  // sign bit and hidden one
    localparam int EXP_LOWER_BOUND = FRA_WID + 1;  // fraction plus round bit

    localparam int SHIFT_WID      = 6;
    localparam int SHIFT_1ST_WID  = 2;
    localparam int SHIFT_2ND_WID  = 2;
    localparam int SHIFT_LAST_WID = 2;

    localparam int PIPE_DEPTH   = 5;
    localparam int FILL_CNT_WID = $clog2(PIPE_DEPTH + 1);

    localparam int FLOAT_WID = 1 + EXP_WID + MANT_WID;
    localparam int ALIGN_WID = INT_WID + FRA_WID + 1;
    localparam int MANT1_WID = MANT_WID + 1 + (2 ** SHIFT_1ST_WID - 1);
    localparam int MANT2_WID = MANT1_WID + ((2 ** SHIFT_2ND_WID - 1) << SHIFT_1ST_WID);
    localparam int WIDE_WID  = MANT_WID + ALIGN_WID;  // round bit sits at the hidden one

    typedef logic [FLOAT_WID-1:0]                    float_t;
    typedef logic [EXP_WID-1:0]                      exp_t;
    typedef logic [MANT_WID-1:0]                     mant_t;
    typedef logic [SHIFT_WID-1:0]                    shift_t;
    typedef logic [SHIFT_2ND_WID+SHIFT_LAST_WID-1:0] shift_rest_t;
    typedef logic [MANT1_WID-1:0]                    mant1_t;
    typedef logic [MANT2_WID-1:0]                    mant2_t;
    typedef logic [ALIGN_WID-1:0]                    aligned_t;
    typedef logic signed [INT_WID-1:0]               fixed_int_t;
    typedef logic [FRA_WID-1:0]                      fixed_frac_t;
    typedef logic [FRA_WID:0]                        frac_twos_t;
    typedef logic [FILL_CNT_WID-1:0]                 fill_cnt_t;

    localparam exp_t        EXP_SHIFT_BASE = exp_t'(EXP_BIAS - EXP_LOWER_BOUND);
    localparam exp_t        EXP_OVF_BASE   = exp_t'(EXP_BIAS + EXP_UPPER_BOUND);
    localparam float_t      MIN_FLOAT      = {1'b1, exp_t'(EXP_BIAS + INT_WID - 1), mant_t'(0)};
    localparam fixed_int_t  FIX_INT_MAX    = fixed_int_t'({1'b0, {(INT_WID - 1){1'b1}}});
    localparam fixed_int_t  FIX_INT_MIN    = fixed_int_t'({1'b1, {(INT_WID - 1){1'b0}}});
    localparam fixed_frac_t FIX_FRAC_MAX   = '1;
    localparam fill_cnt_t   FILL_FULL      = fill_cnt_t'(PIPE_DEPTH);

    typedef struct packed {
        logic sign;
        logic zero;
        logic denorm;
        logic nan;
        logic infinity;
        logic overflow;
        logic underflow;
        logic result_clr;  // force result to zero
        logic result_set;  // force result to max or min
    } conv_flags_t;

endpackage

`default_nettype wire

//--- verilog/float_classifier.sv
`default_nettype none

module float_classifier (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   clk_en,
    input  f2fix_pkg::float_t      float_val,
    output f2fix_pkg::mant1_t      mant_shifted,
    output f2fix_pkg::shift_rest_t shift_rest,
    output f2fix_pkg::conv_flags_t flags
);

    logic                   sign;
    f2fix_pkg::exp_t        exponent;
    f2fix_pkg::mant_t       mantissa;
    f2fix_pkg::exp_t        exp_diff;
    f2fix_pkg::shift_t      shift_amt;
    logic                   exp_zero;
    logic                   exp_ones;
    logic                   mant_zero;
    logic                   is_min;
    f2fix_pkg::conv_flags_t flags_next;

    assign sign     = float_val[f2fix_pkg::FLOAT_WID-1];
    assign exponent = float_val[f2fix_pkg::MANT_WID +: f2fix_pkg::EXP_WID];
    assign mantissa = float_val[f2fix_pkg::MANT_WID-1:0];

    // unbiased exponent plus lower bound
    assign exp_diff  = exponent - f2fix_pkg::EXP_SHIFT_BASE;
    assign shift_amt = exp_diff[f2fix_pkg::SHIFT_WID-1:0];

    assign exp_zero  = (exponent == '0);
    assign exp_ones  = (exponent == '1);
    assign mant_zero = (mantissa == '0);
    assign is_min    = (float_val == f2fix_pkg::MIN_FLOAT);  // exactly -2^15

    always_comb begin
        flags_next           = '0;
        flags_next.sign      = sign;
        flags_next.zero      = exp_zero & mant_zero;
        flags_next.denorm    = exp_zero & ~mant_zero;
        flags_next.nan       = exp_ones & ~mant_zero;
        flags_next.infinity  = exp_ones & mant_zero;
        flags_next.overflow  = (exponent > f2fix_pkg::EXP_OVF_BASE) & ~is_min;
        flags_next.underflow = (exponent < f2fix_pkg::EXP_SHIFT_BASE);

        flags_next.result_clr = flags_next.zero | flags_next.nan | flags_next.denorm
                              | flags_next.underflow;
        flags_next.result_set = flags_next.infinity | flags_next.overflow | is_min;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mant_shifted <= '0;
            shift_rest   <= '0;
            flags        <= '0;
        end else if (clk_en) begin
            mant_shifted <= f2fix_pkg::mant1_t'({1'b1, mantissa})
                            << shift_amt[f2fix_pkg::SHIFT_1ST_WID-1:0];  // low slice
            shift_rest   <= shift_amt[f2fix_pkg::SHIFT_WID-1:f2fix_pkg::SHIFT_1ST_WID];
            flags        <= flags_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/mantissa_shifter.sv
`default_nettype none

module mantissa_shifter (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   clk_en,
    input  f2fix_pkg::mant1_t      mant_shifted,
    input  f2fix_pkg::shift_rest_t shift_rest,
    input  f2fix_pkg::conv_flags_t flags_in,
    output f2fix_pkg::aligned_t    aligned,
    output f2fix_pkg::conv_flags_t flags_out
);

    f2fix_pkg::mant2_t                  mant_r2;
    logic [f2fix_pkg::SHIFT_LAST_WID-1:0] shift_last_r2;
    f2fix_pkg::conv_flags_t             flags_r2;
    logic [f2fix_pkg::WIDE_WID-1:0]     mant_wide;

    // middle slice weighted by the low slice width
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mant_r2       <= '0;
            shift_last_r2 <= '0;
            flags_r2      <= '0;
        end else if (clk_en) begin
            mant_r2       <= f2fix_pkg::mant2_t'(mant_shifted)
                             << {shift_rest[f2fix_pkg::SHIFT_2ND_WID-1:0],
                                 {f2fix_pkg::SHIFT_1ST_WID{1'b0}}};
            shift_last_r2 <= shift_rest[f2fix_pkg::SHIFT_2ND_WID +: f2fix_pkg::SHIFT_LAST_WID];
            flags_r2      <= flags_in;
        end
    end

    always_comb begin
        mant_wide = {{(f2fix_pkg::WIDE_WID - f2fix_pkg::MANT2_WID){1'b0}}, mant_r2}
                    << {shift_last_r2,
                        {(f2fix_pkg::SHIFT_1ST_WID + f2fix_pkg::SHIFT_2ND_WID){1'b0}}};
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            aligned   <= '0;
            flags_out <= '0;
        end else if (clk_en) begin
            aligned   <= mant_wide[f2fix_pkg::MANT_WID +: f2fix_pkg::ALIGN_WID];  // int, frac, round
            flags_out <= flags_r2;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fixed_rounder.sv
`default_nettype none

module fixed_rounder (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   clk_en,
    input  f2fix_pkg::aligned_t    aligned,
    input  f2fix_pkg::conv_flags_t flags_in,
    output f2fix_pkg::fixed_int_t  int_part,
    output f2fix_pkg::fixed_frac_t frac_part,
    output f2fix_pkg::frac_twos_t  frac_twos,
    output f2fix_pkg::conv_flags_t flags_out
);

    logic                          round_bit;
    f2fix_pkg::fixed_frac_t        frac_raw;
    logic [f2fix_pkg::INT_WID-1:0] int_raw;
    logic [f2fix_pkg::FRA_WID:0]   frac_sum;
    f2fix_pkg::fixed_frac_t        frac_rnd;
    logic                          frac_carry;

    assign round_bit = aligned[0];
    assign frac_raw  = aligned[1 +: f2fix_pkg::FRA_WID];
    assign int_raw   = aligned[f2fix_pkg::FRA_WID+1 +: f2fix_pkg::INT_WID];

    // half up on the magnitude
    always_comb begin
        frac_sum   = {1'b0, frac_raw} + round_bit;
        frac_rnd   = frac_sum[f2fix_pkg::FRA_WID-1:0];
        frac_carry = frac_sum[f2fix_pkg::FRA_WID];
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            int_part  <= '0;
            frac_part <= '0;
            frac_twos <= '0;
            flags_out <= '0;
        end else if (clk_en) begin
            int_part  <= f2fix_pkg::fixed_int_t'(int_raw + frac_carry);  // carry into integer
            frac_part <= frac_rnd;
            frac_twos <= {1'b0, ~frac_rnd} + 1'b1;  // top bit set only for zero fraction
            flags_out <= flags_in;
        end
    end

endmodule

`default_nettype wire

//--- verilog/output_saturator.sv
`default_nettype none

module output_saturator (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   clk_en,
    input  f2fix_pkg::fixed_int_t  int_part,
    input  f2fix_pkg::fixed_frac_t frac_part,
    input  f2fix_pkg::frac_twos_t  frac_twos,
    input  f2fix_pkg::conv_flags_t flags_in,
    output f2fix_pkg::fixed_int_t  fixed_integer,
    output f2fix_pkg::fixed_frac_t fixed_fraction,
    output logic                   overflow,
    output logic                   underflow,
    output logic                   nan,
    output logic                   infinity,
    output logic                   denorm,
    output logic                   zero
);

    f2fix_pkg::fixed_int_t  res_int;
    f2fix_pkg::fixed_frac_t res_frac;

    // a negative value keeps a positive fraction and the integer absorbs the borrow
    always_comb begin
        if (flags_in.sign) begin
            res_int  = ~int_part + frac_twos[f2fix_pkg::FRA_WID];
            res_frac = frac_twos[f2fix_pkg::FRA_WID-1:0];
        end else begin
            res_int  = int_part;
            res_frac = frac_part;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fixed_integer  <= '0;
            fixed_fraction <= '0;
            overflow       <= 1'b0;
            underflow      <= 1'b0;
            nan            <= 1'b0;
            infinity       <= 1'b0;
            denorm         <= 1'b0;
            zero           <= 1'b0;
        end else if (clk_en) begin
            nan      <= flags_in.nan;
            infinity <= flags_in.infinity;
            denorm   <= flags_in.denorm;
            zero     <= flags_in.zero;

            if (flags_in.infinity) begin
                overflow  <= 1'b1;
                underflow <= 1'b0;
            end else if (flags_in.zero | flags_in.nan | flags_in.denorm) begin
                overflow  <= 1'b0;
                underflow <= 1'b0;
            end else begin
                overflow  <= flags_in.overflow;
                underflow <= flags_in.underflow;
            end

            if (flags_in.result_clr) begin
                fixed_integer  <= '0;
                fixed_fraction <= '0;
            end else if (flags_in.result_set) begin
                fixed_integer  <= flags_in.sign ? f2fix_pkg::FIX_INT_MIN : f2fix_pkg::FIX_INT_MAX;
                fixed_fraction <= flags_in.sign ? '0 : f2fix_pkg::FIX_FRAC_MAX;
            end else if (!flags_in.sign && res_int[f2fix_pkg::INT_WID-1]) begin
                fixed_integer  <= f2fix_pkg::FIX_INT_MAX;  // rounding carried into sign bit
                fixed_fraction <= f2fix_pkg::FIX_FRAC_MAX;
            end else begin
                fixed_integer  <= res_int;
                fixed_fraction <= res_frac;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fill_counter.sv
`default_nettype none

module fill_counter (
    input  logic clk,
    input  logic rstn,
    input  logic clk_en,
    output logic done
);

    f2fix_pkg::fill_cnt_t fill_cnt;
    f2fix_pkg::fill_cnt_t fill_next;

    assign fill_next = (fill_cnt == f2fix_pkg::FILL_FULL) ? fill_cnt : fill_cnt + 1'b1;  // saturate

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fill_cnt <= '0;
            done     <= 1'b0;
        end else if (clk_en) begin
            fill_cnt <= fill_next;
            done     <= (fill_next == f2fix_pkg::FILL_FULL);  // stays high once full
        end
    end

endmodule

`default_nettype wire

//--- verilog/f2fix_top.sv
`default_nettype none

module f2fix_top (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   clk_en,
    input  f2fix_pkg::float_t      float_val,
    output f2fix_pkg::fixed_int_t  fixed_integer,
    output f2fix_pkg::fixed_frac_t fixed_fraction,
    output logic                   overflow,
    output logic                   underflow,
    output logic                   nan,
    output logic                   infinity,
    output logic                   denorm,
    output logic                   zero,
    output logic                   done
);

    f2fix_pkg::mant1_t      mant_shifted;
    f2fix_pkg::shift_rest_t shift_rest;
    f2fix_pkg::conv_flags_t flags_st1;
    f2fix_pkg::aligned_t    aligned;
    f2fix_pkg::conv_flags_t flags_st3;
    f2fix_pkg::fixed_int_t  int_part;
    f2fix_pkg::fixed_frac_t frac_part;
    f2fix_pkg::frac_twos_t  frac_twos;
    f2fix_pkg::conv_flags_t flags_st4;

    float_classifier u_classifier (
        .clk          (clk),
        .rstn         (rstn),
        .clk_en       (clk_en),
        .float_val    (float_val),
        .mant_shifted (mant_shifted),
        .shift_rest   (shift_rest),
        .flags        (flags_st1)
    );

    mantissa_shifter u_shifter (  // stages 2 and 3
        .clk          (clk),
        .rstn         (rstn),
        .clk_en       (clk_en),
        .mant_shifted (mant_shifted),
        .shift_rest   (shift_rest),
        .flags_in     (flags_st1),
        .aligned      (aligned),
        .flags_out    (flags_st3)
    );

    fixed_rounder u_rounder (
        .clk       (clk),
        .rstn      (rstn),
        .clk_en    (clk_en),
        .aligned   (aligned),
        .flags_in  (flags_st3),
        .int_part  (int_part),
        .frac_part (frac_part),
        .frac_twos (frac_twos),
        .flags_out (flags_st4)
    );

    output_saturator u_saturator (
        .clk            (clk),
        .rstn           (rstn),
        .clk_en         (clk_en),
        .int_part       (int_part),
        .frac_part      (frac_part),
        .frac_twos      (frac_twos),
        .flags_in       (flags_st4),
        .fixed_integer  (fixed_integer),
        .fixed_fraction (fixed_fraction),
        .overflow       (overflow),
        .underflow      (underflow),
        .nan            (nan),
        .infinity       (infinity),
        .denorm         (denorm),
        .zero           (zero)
    );

    fill_counter u_fill (
        .clk    (clk),
        .rstn   (rstn),
        .clk_en (clk_en),
        .done   (done)
    );

endmodule

`default_nettype wire

//--- tests/f2fix_asserts.sv
`default_nettype none

module f2fix_asserts (
    input logic                   clk,
    input logic                   rstn,
    input logic                   clk_en,
    input f2fix_pkg::fixed_int_t  fixed_integer,
    input f2fix_pkg::fixed_frac_t fixed_fraction,
    input logic                   overflow,
    input logic                   underflow,
    input logic                   nan,
    input logic                   infinity,
    input logic                   denorm,
    input logic                   zero,
    input logic                   done
);

    timeunit 1ns;
    timeprecision 1ns;

    class_onehot: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({nan, infinity, zero, denorm}))
        else $error("more than one class flag is high");

    range_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(overflow && underflow))
        else $error("overflow and underflow are high together");

    stall_hold: assert property (@(posedge clk) disable iff (!rstn)
        !clk_en |=> $stable({fixed_integer, fixed_fraction, overflow, underflow,
                             nan, infinity, denorm, zero, done}))
        else $error("outputs changed while clk_en was low");

    done_sticky: assert property (@(posedge clk) disable iff (!rstn)
        done |=> done)
        else $error("done fell outside reset");

endmodule

bind f2fix_top f2fix_asserts u_asserts (
    .clk            (clk),
    .rstn           (rstn),
    .clk_en         (clk_en),
    .fixed_integer  (fixed_integer),
    .fixed_fraction (fixed_fraction),
    .overflow       (overflow),
    .underflow      (underflow),
    .nan            (nan),
    .infinity       (infinity),
    .denorm         (denorm),
    .zero           (zero),
    .done           (done)
);

`default_nettype wire

//--- tests/f2fix_tb.sv
`default_nettype none

module f2fix_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY      = 5;  // enabled edges from input to output
    localparam int N_RANDOM     = 40;
    localparam int N_FLUSH      = LATENCY - 1;

    // flag order from bit 5 down is overflow underflow nan infinity denorm zero
    localparam logic [5:0] NO_FLAGS = 6'b000000;
    localparam logic [5:0] FL_OVF   = 6'b100000;
    localparam logic [5:0] FL_UNF   = 6'b010000;
    localparam logic [5:0] FL_NAN   = 6'b001000;
    localparam logic [5:0] FL_INF   = 6'b000100;
    localparam logic [5:0] FL_DEN   = 6'b000010;
    localparam logic [5:0] FL_ZERO  = 6'b000001;

    typedef struct packed {
        f2fix_pkg::float_t      flt;
        logic                   en;
        f2fix_pkg::fixed_int_t  int_val;
        f2fix_pkg::fixed_frac_t frac_val;
        logic [5:0]             flg;
    } vec_t;

    logic                   clk;
    logic                   rstn;
    logic                   clk_en;
    f2fix_pkg::float_t      float_val;
    f2fix_pkg::fixed_int_t  fixed_integer;
    f2fix_pkg::fixed_frac_t fixed_fraction;
    logic                   overflow;
    logic                   underflow;
    logic                   nan;
    logic                   infinity;
    logic                   denorm;
    logic                   zero;
    logic                   done;

    vec_t   stim[$];
    string  names[$];
    vec_t   pending[$];
    string  pend_names[$];
    vec_t   shown;
    string  shown_name;
    int     errors;
    int     en_edges;
    integer seed;
    logic   stim_ready;

    f2fix_top UUT (
        .clk            (clk),
        .rstn           (rstn),
        .clk_en         (clk_en),
        .float_val      (float_val),
        .fixed_integer  (fixed_integer),
        .fixed_fraction (fixed_fraction),
        .overflow       (overflow),
        .underflow      (underflow),
        .nan            (nan),
        .infinity       (infinity),
        .denorm         (denorm),
        .zero           (zero),
        .done           (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic add_entry(input string name, input f2fix_pkg::float_t flt, input logic en,
                             input f2fix_pkg::fixed_int_t int_val,
                             input f2fix_pkg::fixed_frac_t frac_val, input logic [5:0] flg);
        vec_t v;
        v = '{flt: flt, en: en, int_val: int_val, frac_val: frac_val, flg: flg};
        stim.push_back(v);
        names.push_back(name);
    endtask

    // m is |x| times 2^16 rounded half up and a negative x gives -m as a 32-bit word
    function automatic vec_t expect_conv(input f2fix_pkg::float_t flt);
        vec_t        v;
        logic [63:0] m;
        logic [31:0] w;
        int          e;
        int          k;
        e = {24'd0, flt[30:23]};
        k = e - 134;  // bias plus mantissa bits minus fraction bits
        m = {40'd0, 1'b1, flt[22:0]};
        if (k >= 0)
            m = m << k;
        else
            m = (m + (64'd1 << (-k - 1))) >> (-k);
        v     = '0;
        v.flt = flt;
        v.en  = 1'b1;
        if (e - 127 >= 15 && flt != 32'hC700_0000) begin  // |x| at or above 2^15
            w     = flt[31] ? 32'h8000_0000 : 32'h7FFF_FFFF;
            v.flg = FL_OVF;
        end else if (e - 127 < -17) begin
            w     = 32'd0;
            v.flg = FL_UNF;
        end else if (!flt[31]) begin
            w = (m >= 64'h8000_0000) ? 32'h7FFF_FFFF : m[31:0];
        end else begin
            w = 32'd0 - m[31:0];
        end
        v.int_val  = w[31:16];
        v.frac_val = w[15:0];
        return v;
    endfunction

    task automatic check_fixed(input string name, input f2fix_pkg::fixed_int_t exp_int,
                               input f2fix_pkg::fixed_frac_t exp_frac,
                               input f2fix_pkg::fixed_int_t act_int,
                               input f2fix_pkg::fixed_frac_t act_frac);
        if (act_int !== exp_int || act_frac !== exp_frac) begin
            $display("error %s: fixed expected %h.%h actual %h.%h",
                     name, exp_int, exp_frac, act_int, act_frac);
            errors++;
        end
    endtask

    task automatic check_flags(input string name, input string flag, input logic exp_val,
                               input logic act_val);
        if (act_val !== exp_val) begin
            $display("error %s: %s expected %b actual %b", name, flag, exp_val, act_val);
            errors++;
        end
    endtask

    task automatic check_done(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val) begin
            $display("error %s: done expected %b actual %b", name, exp_val, act_val);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] r_exp;
        logic [31:0] r_man;
        int          e_val;
        vec_t        v;
        rstn       = 1'b0;
        clk_en     = 1'b0;
        float_val  = '0;
        errors     = 0;
        en_edges   = 0;
        seed       = 32'h10e;
        shown      = '0;
        shown_name = "reset";
        stim_ready = 1'b0;

        add_entry("pos_1p5",          32'h3FC0_0000, 1'b1, 16'h0001, 16'h8000, NO_FLAGS);
        add_entry("neg_1p5",          32'hBFC0_0000, 1'b1, 16'hFFFE, 16'h8000, NO_FLAGS);
        add_entry("stall_filling",    32'hDEAD_BEEF, 1'b0, 16'h0000, 16'h0000, NO_FLAGS);
        add_entry("round_up_lsb",     32'h37C0_0000, 1'b1, 16'h0000, 16'h0002, NO_FLAGS);
        add_entry("smallest_step",    32'h3700_0000, 1'b1, 16'h0000, 16'h0001, NO_FLAGS);
        add_entry("frac_carry",       32'h3FFF_FFFF, 1'b1, 16'h0002, 16'h0000, NO_FLAGS);
        add_entry("neg_frac_carry",   32'hBFFF_FFFF, 1'b1, 16'hFFFE, 16'h0000, NO_FLAGS);
        add_entry("pos_12345_678",    32'h4640_E6B6, 1'b1, 16'h3039, 16'hAD80, NO_FLAGS);
        add_entry("stall_a",          32'hDEAD_BEEF, 1'b0, 16'h0000, 16'h0000, NO_FLAGS);
        add_entry("stall_b",          32'h1234_5678, 1'b0, 16'h0000, 16'h0000, NO_FLAGS);
        add_entry("neg_12345_678",    32'hC640_E6B6, 1'b1, 16'hCFC6, 16'h5280, NO_FLAGS);
        add_entry("pos_zero",         32'h0000_0000, 1'b1, 16'h0000, 16'h0000, FL_ZERO);
        add_entry("neg_zero",         32'h8000_0000, 1'b1, 16'h0000, 16'h0000, FL_ZERO);
        add_entry("denormal",         32'h0000_0001, 1'b1, 16'h0000, 16'h0000, FL_DEN);
        add_entry("neg_denormal",     32'h807F_FFFF, 1'b1, 16'h0000, 16'h0000, FL_DEN);
        add_entry("quiet_nan",        32'h7FC0_0000, 1'b1, 16'h0000, 16'h0000, FL_NAN);
        add_entry("pos_inf",          32'h7F80_0000, 1'b1, 16'h7FFF, 16'hFFFF, FL_INF | FL_OVF);
        add_entry("stall_c",          32'h4000_0000, 1'b0, 16'h0000, 16'h0000, NO_FLAGS);
        add_entry("neg_inf",          32'hFF80_0000, 1'b1, 16'h8000, 16'h0000, FL_INF | FL_OVF);
        add_entry("pos_40000",        32'h471C_4000, 1'b1, 16'h7FFF, 16'hFFFF, FL_OVF);
        add_entry("neg_40000",        32'hC71C_4000, 1'b1, 16'h8000, 16'h0000, FL_OVF);
        add_entry("neg_32768",        32'hC700_0000, 1'b1, 16'h8000, 16'h0000, NO_FLAGS);
        add_entry("pos_32768",        32'h4700_0000, 1'b1, 16'h7FFF, 16'hFFFF, FL_OVF);
        add_entry("tiny_1e_7",        32'h33D6_BF95, 1'b1, 16'h0000, 16'h0000, FL_UNF);
        add_entry("below_small_step", 32'h36FF_FFFF, 1'b1, 16'h0000, 16'h0000, FL_UNF);

        for (int n = 0; n < N_RANDOM; n++) begin
            r_exp = $random(seed);
            r_man = $random(seed);
            e_val = 100 + int'(r_exp[15:0] % 16'd51);  // exponents 100 to 150
            v     = expect_conv({r_man[31], f2fix_pkg::exp_t'(e_val), r_man[22:0]});
            stim.push_back(v);
            names.push_back($sformatf("random_%0d", n));
        end
        for (int n = 0; n < N_FLUSH; n++)
            add_entry($sformatf("flush_%0d", n), 32'h0, 1'b1, 16'h0, 16'h0, FL_ZERO);
        stim_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;

        for (int idx = 0; idx <= stim.size(); idx++) begin
            @(posedge clk);
            if (idx < stim.size()) begin
                float_val <= stim[idx].flt;
                clk_en    <= stim[idx].en;
            end else begin
                clk_en <= 1'b0;
            end
            if (idx > 0 && stim[idx-1].en) begin  // this edge took entry idx-1
                pending.push_back(stim[idx-1]);
                pend_names.push_back(names[idx-1]);
                en_edges++;
                if (pending.size() == LATENCY) begin
                    shown      = pending.pop_front();
                    shown_name = pend_names.pop_front();
                end
            end
            @(negedge clk);
            check_fixed(shown_name, shown.int_val, shown.frac_val, fixed_integer, fixed_fraction);
            check_flags(shown_name, "overflow", shown.flg[5], overflow);
            check_flags(shown_name, "underflow", shown.flg[4], underflow);
            check_flags(shown_name, "nan", shown.flg[3], nan);
            check_flags(shown_name, "infinity", shown.flg[2], infinity);
            check_flags(shown_name, "denorm", shown.flg[1], denorm);
            check_flags(shown_name, "zero", shown.flg[0], zero);
            check_done($sformatf("enabled_edge_%0d", en_edges), en_edges >= LATENCY, done);
        end

        $display("%0d entries applied, %0d enabled edges, %0d errors",
                 stim.size(), en_edges, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // stops a run that outlives the stimulus
    initial begin
        wait (stim_ready);
        repeat (stim.size() + RESET_CYCLES + 20) @(posedge clk);
        $display("watchdog expired, the stimulus loop did not finish in time");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/f2fix_pkg.sv
verilog/float_classifier.sv
verilog/mantissa_shifter.sv
verilog/fixed_rounder.sv
verilog/output_saturator.sv
verilog/fill_counter.sv
verilog/f2fix_top.sv
tests/f2fix_asserts.sv
tests/f2fix_tb.sv

//--- Makefile
SIM       := verilator
TOP       := f2fix_tb
RTL_TOP   := f2fix_top
FILELIST  := sources.f
SIMFLAGS  := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only -Wall
BUILD_DIR := obj_dir
PASS_MSG  := TESTS PASSED

RTL_SRCS := $(shell grep '^verilog/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
